/* filelist.f */
+incdir+source
source/ntm_pkg.sv
source/ntm_elem_if.sv
source/ntm_apb_regs.sv
source/ntm_gate_differentiator.sv
source/ntm_gradient_accumulator.sv
source/ntm_output_trainer.sv
source/ntm_trainer_top.sv
tb/ntm_trainer_asserts.sv
tb/ntm_trainer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the trainer testbench with Verilator, run it, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_trainer_tb \
  -f filelist.f \
  -o ntm_trainer_sim

./obj_dir/ntm_trainer_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

/* source/ntm_apb_regs.sv */
// APB slave of the trainer: input vector buffers, CTRL pulses, STATUS
// Result reads take one wait cycle while the accumulator word is fetched
`timescale 1ns/10ps
`default_nettype none
`include "ntm_settings.svh"

module ntm_apb_regs import ntm_pkg::*; (
  input  wire logic                       CLK,
  input  wire logic                       RST,
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [`NTM_APB_ADDR_W-1:0] paddr,
  input  wire logic [31:0]                pwdata,
  output logic      [31:0]                prdata,
  output logic                            pready,
  output logic                            pslverr,
  output data_t                           dh [`NTM_SIZE_L],
  output data_t                           a [`NTM_SIZE_L],
  output data_t                           o [`NTM_SIZE_L],
  output data_t                           x [`NTM_SIZE_X],
  output logic                            start,
  output logic                            clear,
  input  wire logic                       busy,
  output logic                            rd_req,
  output rd_addr_t                        rd_addr,
  input  wire data_t                      rd_data
);

  localparam int L  = `NTM_SIZE_L;
  localparam int X  = `NTM_SIZE_X;
  localparam int AW = `NTM_APB_ADDR_W;

  logic hit_ctrl, hit_status, hit_dh, hit_a, hit_o, hit_x, hit_dw, hit_db;
  logic mapped, res_rd, err;
  logic setup, access, wr_en;
  logic rd_pend;
  l_idx_t l_sel;
  x_idx_t x_sel;
  logic [1:0] cmd_bits;
  logic [31:0] rd_mux;

  // Word-aligned address inside a block of words
  function automatic logic in_region(logic [AW-1:0] addr, logic [AW-1:0] base, int words);
    return (addr[1:0] == 2'b00) && (addr >= base) &&
           (int'(addr) < int'(base) + 4 * words);
  endfunction

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign hit_ctrl   = (paddr == REG_CTRL);
  assign hit_status = (paddr == REG_STATUS);
  assign hit_dh     = in_region(paddr, REG_DH, L);
  assign hit_a      = in_region(paddr, REG_A, L);
  assign hit_o      = in_region(paddr, REG_O, L);
  assign hit_x      = in_region(paddr, REG_X, X);
  assign hit_dw     = in_region(paddr, REG_DW, L * X);
  assign hit_db     = in_region(paddr, REG_DB, L);
  assign mapped     = hit_ctrl | hit_status | hit_dh | hit_a | hit_o | hit_x | hit_dw | hit_db;

  // Blocks sit on their own size, so the word index is a bit slice
  assign l_sel = paddr[2 +: $bits(l_idx_t)];
  assign x_sel = paddr[2 +: $bits(x_idx_t)];

  // Slave error: unmapped, read-only target, or any write during a step
  assign err    = !mapped || (pwrite && (hit_status || hit_dw || hit_db || busy));
  assign res_rd = !pwrite && (hit_dw || hit_db);

  // APB phases
  assign setup  = psel && !penable;
  assign access = psel && penable;
  assign wr_en  = access && pready && pwrite && !pslverr;

  // Result fetch goes out with the setup cycle, data back one cycle later
  assign rd_req = setup && res_rd;

  always_comb begin
    rd_addr = '0;
    if (hit_db) begin
      rd_addr[DW_IDX_W] = 1'b1;
      rd_addr[$bits(l_idx_t)-1:0] = l_sel;
    end else begin
      rd_addr[DW_IDX_W-1:0] = paddr[2 +: DW_IDX_W];
    end
  end

  // Commands fire on the completing write edge
  assign cmd_bits = pwdata[1:0];
  assign start    = wr_en && hit_ctrl && ((cmd_bits & CMD_START) != 2'b00);
  assign clear    = wr_en && hit_ctrl && ((cmd_bits & CMD_CLEAR) != 2'b00);

  // Read mux for the zero-wait registers, CTRL reads as 0
  always_comb begin
    rd_mux = '0;
    if (hit_status) rd_mux[0] = busy;
    else if (hit_dh) rd_mux = 32'(dh[l_sel]);
    else if (hit_a) rd_mux = 32'(a[l_sel]);
    else if (hit_o) rd_mux = 32'(o[l_sel]);
    else if (hit_x) rd_mux = 32'(x[x_sel]);
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      prdata  <= '0;
      rd_pend <= 1'b0;
    end else if (setup) begin
      // Ready on the first access cycle unless a result word is needed
      pready  <= !res_rd;
      pslverr <= err;
      rd_pend <= res_rd;
      prdata  <= rd_mux;
    end else if (rd_pend) begin
      // Wait cycle over, accumulator word is here
      pready  <= 1'b1;
      prdata  <= 32'(rd_data);
      rd_pend <= 1'b0;
    end else if (access && pready) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end
  end

  //////////////////////////////
  // Input buffers
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < L; i++) begin
        dh[i] <= '0;
        a[i]  <= '0;
        o[i]  <= '0;
      end
      for (int i = 0; i < X; i++) begin
        x[i] <= '0;
      end
    end else if (wr_en) begin
      if (hit_dh) dh[l_sel] <= data_t'(pwdata[`NTM_DATA_W-1:0]);
      if (hit_a) a[l_sel] <= data_t'(pwdata[`NTM_DATA_W-1:0]);
      if (hit_o) o[l_sel] <= data_t'(pwdata[`NTM_DATA_W-1:0]);
      if (hit_x) x[x_sel] <= data_t'(pwdata[`NTM_DATA_W-1:0]);
    end
  end

endmodule

`default_nettype wire

/* source/ntm_elem_if.sv */
// One gate-error element on its way from the differentiator to the accumulator
// Valid/ready handshake, source holds all fields until the transfer
`timescale 1ns/10ps
`default_nettype none

interface ntm_elem_if import ntm_pkg::*; ();

  // Handshake
  logic   valid;
  logic   ready;

  // Payload
  l_idx_t idx;
  data_t  err;
  logic   last;

  // Differentiator side
  modport src (output valid, output idx, output err, output last, input ready);

  // Accumulator side
  modport dst (input valid, input idx, input err, input last, output ready);

endinterface

`default_nettype wire

/* source/ntm_gate_differentiator.sv */
// Gate error pipeline: do = ((dh*tanh(a))*o)*(1-o) in Q8.8
// Three stages, one element per cycle, all stages stall together
`timescale 1ns/10ps
`default_nettype none

module ntm_gate_differentiator import ntm_pkg::*; (
  input  wire logic   CLK,
  input  wire logic   RST,
  input  wire logic   in_valid,
  output logic        in_ready,
  input  wire l_idx_t in_idx,
  input  wire logic   in_last,
  input  wire data_t  dh,
  input  wire data_t  a,
  input  wire data_t  o,
  ntm_elem_if.src     elem
);

  logic   adv;
  data_t  tanh_a;

  // Stage 1 clamp and 1-o
  logic   v1, last1;
  l_idx_t idx1;
  data_t  dh1, tanh1, o1, omo1;

  // Stage 2 dh*tanh
  logic   v2, last2;
  l_idx_t idx2;
  data_t  p2, o2, omo2;

  // Move when the output slot is empty or being taken
  assign adv      = !elem.valid || elem.ready;
  assign in_ready = adv;

  // Hard tanh, clamp to +-1.0
  always_comb begin
    if (a > Q_ONE) tanh_a = Q_ONE;
    else if (a < -Q_ONE) tanh_a = -Q_ONE;
    else tanh_a = a;
  end

  // Stage valids
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      v1         <= 1'b0;
      v2         <= 1'b0;
      elem.valid <= 1'b0;
    end else if (adv) begin
      v1         <= in_valid;
      v2         <= v1;
      elem.valid <= v2;
    end
  end

  // Stage payloads
  always_ff @(posedge CLK) begin
    if (adv) begin
      idx1      <= in_idx;
      last1     <= in_last;
      dh1       <= dh;
      tanh1     <= tanh_a;
      o1        <= o;
      omo1      <= Q_ONE - o;
      idx2      <= idx1;
      last2     <= last1;
      p2        <= q_mul(dh1, tanh1);
      o2        <= o1;
      omo2      <= omo1;
      elem.idx  <= idx2;
      elem.last <= last2;
      // Times o, then times 1-o
      elem.err  <= q_mul(q_mul(p2, o2), omo2);
    end
  end

endmodule

`default_nettype wire

/* source/ntm_gradient_accumulator.sv */
// dW and db accumulators of the output gate, one MAC per cycle per column
// Holds ready low while it walks the X columns of an element
`timescale 1ns/10ps
`default_nettype none
`include "ntm_settings.svh"

module ntm_gradient_accumulator import ntm_pkg::*; (
  input  wire logic     CLK,
  input  wire logic     RST,
  input  wire logic     clear,
  ntm_elem_if.dst       elem,
  input  wire data_t    x [`NTM_SIZE_X],
  output logic          acc_done,
  input  wire logic     rd_req,
  input  wire rd_addr_t rd_addr,
  output data_t         rd_data
);

  localparam int L = `NTM_SIZE_L;
  localparam int X = `NTM_SIZE_X;

  // Accumulators, dW word l*X+x
  data_t dw_mem [L*X];
  data_t db_mem [L];

  logic   ready_q, run_q;
  x_idx_t col_q;
  l_idx_t idx_q;
  data_t  err_q;
  logic   last_q;
  logic   take, mac_en, col_end;
  l_idx_t cur_idx;
  data_t  cur_err;
  logic   cur_last;
  int     dw_sel;

  assign elem.ready = ready_q;
  assign take       = elem.valid && ready_q;

  // Column 0 works straight off the interface, later columns off the latch
  assign mac_en   = take || run_q;
  assign cur_idx  = run_q ? idx_q : elem.idx;
  assign cur_err  = run_q ? err_q : elem.err;
  assign cur_last = run_q ? last_q : elem.last;
  assign col_end  = mac_en && (int'(col_q) == X - 1);
  assign dw_sel   = int'(cur_idx) * X + int'(col_q);

  // Last column of the final element ends the step
  assign acc_done = col_end && cur_last;

  //////////////////////////////
  // Column walk
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready_q <= 1'b0;
      run_q   <= 1'b0;
      col_q   <= '0;
    end else begin
      run_q   <= mac_en && !col_end;
      ready_q <= !(mac_en && !col_end);
      if (col_end) col_q <= '0;
      else if (mac_en) col_q <= col_q + 1'b1;
    end
  end

  // Element latch and result read port
  always_ff @(posedge CLK) begin
    if (take) begin
      idx_q  <= elem.idx;
      err_q  <= elem.err;
      last_q <= elem.last;
    end
    if (rd_req) begin
      if (rd_addr[DW_IDX_W]) rd_data <= db_mem[rd_addr[$bits(l_idx_t)-1:0]];
      else rd_data <= dw_mem[rd_addr[DW_IDX_W-1:0]];
    end
  end

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < L * X; i++) dw_mem[i] <= '0;
      for (int i = 0; i < L; i++) db_mem[i] <= '0;
    end else if (clear) begin
      // All words in one cycle
      for (int i = 0; i < L * X; i++) dw_mem[i] <= '0;
      for (int i = 0; i < L; i++) db_mem[i] <= '0;
    end else if (mac_en) begin
      dw_mem[dw_sel] <= dw_mem[dw_sel] + q_mul(cur_err, x[col_q]);
      // db rides along with column 0
      if (col_q == '0) db_mem[cur_idx] <= db_mem[cur_idx] + cur_err;
    end
  end

endmodule

`default_nettype wire

/* source/ntm_output_trainer.sv */
// Step controller, sweeps the L elements through the gate differentiator
// busy spans START to the accumulator's last element, done pulses at its end
`timescale 1ns/10ps
`default_nettype none
`include "ntm_settings.svh"

module ntm_output_trainer import ntm_pkg::*; (
  input  wire logic  CLK,
  input  wire logic  RST,
  input  wire logic  start,
  input  wire data_t dh [`NTM_SIZE_L],
  input  wire data_t a [`NTM_SIZE_L],
  input  wire data_t o [`NTM_SIZE_L],
  output logic       busy,
  output logic       done,
  ntm_elem_if.src    elem,
  input  wire logic  acc_done
);

  localparam int L = `NTM_SIZE_L;

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_DRAIN} state_e;

  state_e state_q;
  l_idx_t l_q;
  logic   in_valid, in_ready, in_last;

  assign busy     = (state_q != S_IDLE);
  assign in_valid = (state_q == S_ISSUE);
  assign in_last  = (int'(l_q) == L - 1);

  // FSM: idle, issue l = 0..L-1, drain until the accumulator is through
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= S_IDLE;
      l_q     <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start) begin
            state_q <= S_ISSUE;
            l_q     <= '0;
          end
        end
        S_ISSUE: begin
          // One element per accepted cycle
          if (in_ready) begin
            if (in_last) state_q <= S_DRAIN;
            else l_q <= l_q + 1'b1;
          end
        end
        S_DRAIN: begin
          if (acc_done) begin
            state_q <= S_IDLE;
            done    <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  ntm_gate_differentiator i_ntm_gate_differentiator (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_idx   (l_q),
    .in_last  (in_last),
    .dh       (dh[l_q]),
    .a        (a[l_q]),
    .o        (o[l_q]),
    .elem     (elem)
  );

endmodule

`default_nettype wire

/* source/ntm_pkg.sv */
// Shared types, command bits and APB register map of the output-gate trainer
// Modules take it by a wildcard import in their header
`default_nettype none
`include "ntm_settings.svh"

package ntm_pkg;

  // Q8.8 word and the full signed product of two words
  typedef logic signed [`NTM_DATA_W-1:0]   data_t;
  typedef logic signed [2*`NTM_DATA_W-1:0] prod_t;

  // Element and column indices
  typedef logic [$clog2(`NTM_SIZE_L)-1:0] l_idx_t;
  typedef logic [$clog2(`NTM_SIZE_X)-1:0] x_idx_t;

  // Result word select, MSB set picks db, else the dW word l*X+x
  localparam int DW_IDX_W = $clog2(`NTM_SIZE_L * `NTM_SIZE_X);
  typedef logic [DW_IDX_W:0] rd_addr_t;

  // 1.0 in Q8.8
  localparam data_t Q_ONE = data_t'(1 << `NTM_FRAC_W);

  // CTRL write bits
  typedef enum logic [1:0] {
    CMD_START = 2'b01,
    CMD_CLEAR = 2'b10
  } ntm_cmd_e;

  // Register byte offsets, 32-bit words
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_CTRL   = 8'h00;
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_STATUS = 8'h04;
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_DH     = 8'h10;
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_A      = 8'h20;
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_O      = 8'h30;
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_X      = 8'h40;
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_DW     = 8'h80;
  localparam logic [`NTM_APB_ADDR_W-1:0] REG_DB     = 8'hC0;

  // Q8.8 multiply, arithmetic shift then keep the low word
  function automatic data_t q_mul(data_t lhs, data_t rhs);
    prod_t full;
    full = prod_t'(lhs) * prod_t'(rhs);
    return data_t'(full >>> `NTM_FRAC_W);
  endfunction

endpackage

`default_nettype wire

/* source/ntm_settings.svh */
// Sizes and widths of the output-gate trainer
// Included by the package and by every module that sizes arrays or buses
`ifndef NTM_SETTINGS_SVH
`define NTM_SETTINGS_SVH

// Signed Q8.8 word
`define NTM_DATA_W 16
`define NTM_FRAC_W 8

// Gate length L and input length X
`define NTM_SIZE_L 4
`define NTM_SIZE_X 4

// APB byte address width
`define NTM_APB_ADDR_W 8

`endif

/* source/ntm_trainer_top.sv */
// Output-gate trainer top level with plain APB slave ports
// done pulses once when a START step has fully accumulated
`timescale 1ns/10ps
`default_nettype none
`include "ntm_settings.svh"

module ntm_trainer_top import ntm_pkg::*; (
  input  wire logic                       CLK,
  input  wire logic                       RST,
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [`NTM_APB_ADDR_W-1:0] paddr,
  input  wire logic [31:0]                pwdata,
  output logic      [31:0]                prdata,
  output logic                            pready,
  output logic                            pslverr,
  output logic                            done
);

  // Input vectors from the register bank
  data_t dh [`NTM_SIZE_L];
  data_t a [`NTM_SIZE_L];
  data_t o [`NTM_SIZE_L];
  data_t x [`NTM_SIZE_X];

  // Control and result read path
  logic     start, clear, busy, acc_done, rd_req;
  rd_addr_t rd_addr;
  data_t    rd_data;

  // Gate errors, differentiator to accumulator
  ntm_elem_if elem_bus ();

  ntm_apb_regs i_ntm_apb_regs (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .dh      (dh),
    .a       (a),
    .o       (o),
    .x       (x),
    .start   (start),
    .clear   (clear),
    .busy    (busy),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  ntm_output_trainer i_ntm_output_trainer (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .dh       (dh),
    .a        (a),
    .o        (o),
    .busy     (busy),
    .done     (done),
    .elem     (elem_bus.src),
    .acc_done (acc_done)
  );

  ntm_gradient_accumulator i_ntm_gradient_accumulator (
    .CLK      (CLK),
    .RST      (RST),
    .clear    (clear),
    .elem     (elem_bus.dst),
    .x        (x),
    .acc_done (acc_done),
    .rd_req   (rd_req),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

/* tb/ntm_trainer_asserts.sv */
// Concurrent checks on the APB slave handshake and the element stream
// Bound into the trainer top level from the testbench
`timescale 1ns/10ps
`default_nettype none
`include "ntm_settings.svh"

module ntm_trainer_asserts (
  input wire logic                       CLK,
  input wire logic                       RST,
  input wire logic                       psel,
  input wire logic                       penable,
  input wire logic [`NTM_APB_ADDR_W-1:0] paddr,
  input wire logic                       elem_valid,
  input wire logic                       elem_ready
);

  // Access phase follows a setup cycle of the same transfer
  a_penable_setup: assert property (@(posedge CLK) disable iff (RST)
    $rose(penable) |-> $past(psel) && psel)
    else $error("PENABLE rose without a setup cycle");

  // Address held for the whole access phase
  a_paddr_stable: assert property (@(posedge CLK) disable iff (RST)
    psel && penable |-> $stable(paddr))
    else $error("PADDR changed during the access phase");

  // Element stays offered until taken
  a_valid_held: assert property (@(posedge CLK) disable iff (RST)
    elem_valid && !elem_ready |=> elem_valid)
    else $error("Element valid dropped before its transfer");

endmodule

`default_nettype wire

/* tb/ntm_trainer_stim.txt */
# op addr data expect, all hex; W write (expect is PSLVERR), R read (expect is PRDATA)
# B reads data words from addr all equal to expect; G start, D wait done, S both; T ends test addr
# 1 reset state
R 04 0 0
R 10 0 0
B 80 10 0
B C0 4 0
T 1 0 0
# 2 one step, a0 and a1 clamp
W 10 0100 0
W 14 FF00 0
W 18 0300 0
W 1C 0080 0
W 20 0300 0
W 24 FE00 0
W 28 0080 0
W 2C FFC0 0
W 30 0080 0
W 34 0040 0
W 38 00C0 0
W 3C 0080 0
W 40 0100 0
W 44 FF00 0
W 48 0200 0
W 4C 0050 0
R 14 0 FFFFFF00
R 4C 0 50
S 0 0 0
R 80 0 40
R 84 0 FFFFFFC0
R 88 0 80
R 8C 0 14
R 90 0 30
R 94 0 FFFFFFD0
R 98 0 60
R 9C 0 F
R A0 0 48
R A4 0 FFFFFFB8
R A8 0 90
R AC 0 16
R B0 0 FFFFFFF8
R B4 0 8
R B8 0 FFFFFFF0
R BC 0 FFFFFFFD
R C0 0 40
R C4 0 30
R C8 0 48
R CC 0 FFFFFFF8
T 2 0 0
# 3 two more steps with larger dh0 and x2, word 88 wraps
W 10 7F00 0
W 48 0400 0
S 0 0 0
S 0 0 0
R 80 0 3FC0
R 84 0 FFFFC040
R 88 0 FFFFFE80
R 8C 0 13EC
R 90 0 90
R 98 0 1E0
R A4 0 FFFFFF28
R AC 0 42
R B0 0 FFFFFFE8
R B4 0 18
R B8 0 FFFFFFB0
R BC 0 FFFFFFF7
R C0 0 3FC0
R C4 0 90
R C8 0 D8
R CC 0 FFFFFFE8
T 3 0 0
# 4 clear, then one step alone
W 00 2 0
B 80 10 0
B C0 4 0
S 0 0 0
R 80 0 1FC0
R 84 0 FFFFE040
R 88 0 7F00
R 8C 0 9EC
R 98 0 C0
R BC 0 FFFFFFFD
R C0 0 1FC0
R CC 0 FFFFFFF8
T 4 0 0
# 5 rejected writes, including dh and clear during a step
W 00 2 0
W 84 1234 1
W 50 1 1
W 04 1 1
G 0 0 0
W 10 0100 1
W 00 2 1
D 0 0 0
R 10 0 7F00
S 0 0 0
R 80 0 3F80
R 84 0 FFFFC080
R 88 0 FFFFFE00
R C0 0 3F80
R CC 0 FFFFFFF0
T 5 0 0
# 6 busy and done over two steps
R 04 0 0
S 0 0 0
R 04 0 0
S 0 0 0
T 6 0 0

/* tb/ntm_trainer_tb.sv */
// Testbench of the output-gate trainer, driven over APB from the stim script under tb
// Each script line is one bus operation or step command with its expected response
`timescale 1ns/10ps
`default_nettype none
`include "ntm_settings.svh"

module ntm_trainer_tb import ntm_pkg::*; ;

  localparam int    CLK_PERIOD_NS = 8;
  localparam int    RESET_CYCLES  = 5;
  localparam int    PREADY_LIMIT  = 16;
  localparam int    STEP_LIMIT    = 200;
  localparam int    BUSY_POLLS    = 8;
  localparam string STIM_PATH     = "tb/ntm_trainer_stim.txt";

  logic                       CLK;
  logic                       RST;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`NTM_APB_ADDR_W-1:0] paddr;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;
  logic                       done;

  // Run bookkeeping
  int checks = 0;
  int errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  int tests_run = 0;
  int watchdog_ns = 0;
  int done_cnt = 0;
  int step_base = 0;
  int xfer_waits = 0;

  ntm_trainer_top i_ntm_trainer_top (
    .CLK     (CLK),
    .RST     (RST),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .done    (done)
  );

  bind ntm_trainer_top ntm_trainer_asserts i_ntm_trainer_asserts (
    .CLK        (CLK),
    .RST        (RST),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .elem_valid (elem_bus.valid),
    .elem_ready (elem_bus.ready)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD_NS / 2) CLK = ~CLK;
  end

  // done is registered, so the falling edge sees it settled
  always @(negedge CLK) begin
    if (!RST && done) done_cnt++;
  end

  // Run limit from the script length
  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("ERROR: watchdog expired after %0d ns, the run is stopped", watchdog_ns);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // Bus and check helpers
  //////////////////////////////

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  // One APB transfer, setup then access until PREADY
  task automatic apb_xfer(input logic wr, input logic [`NTM_APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waits;
    waits = 0;
    @(posedge CLK);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(posedge CLK);
    while (!pready && waits < PREADY_LIMIT) begin
      waits++;
      @(posedge CLK);
    end
    xfer_waits = waits;
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("ERROR: no PREADY within %0d cycles at address 0x%02h", PREADY_LIMIT, addr);
      count_error();
      err = 1'b1;
    end
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic do_write(input logic [`NTM_APB_ADDR_W-1:0] addr, input logic [31:0] data,
                          input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    checks++;
    test_checks++;
    if (err !== exp_err) begin
      $display("FAILED at %0d ns: write 0x%02h gave PSLVERR %0b, expected %0b",
               $time, addr, err, exp_err);
      count_error();
    end else if (!exp_err && xfer_waits != 0) begin
      // Accepted writes complete in the first access cycle
      $display("FAILED at %0d ns: write 0x%02h took %0d wait cycles, expected 0",
               $time, addr, xfer_waits);
      count_error();
    end
  endtask

  task automatic do_read(input logic [`NTM_APB_ADDR_W-1:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    int          exp_waits;
    // One wait cycle for a dW or db word, none elsewhere
    exp_waits = (addr >= REG_DW && addr < REG_DB + 8'h10) ? 1 : 0;
    apb_xfer(1'b0, addr, '0, rdata, err);
    checks++;
    test_checks++;
    if (err !== 1'b0) begin
      $display("FAILED at %0d ns: read 0x%02h returned PSLVERR", $time, addr);
      count_error();
    end else if (rdata !== exp) begin
      $display("FAILED at %0d ns: read 0x%02h got 0x%08h, expected 0x%08h",
               $time, addr, rdata, exp);
      count_error();
    end else if (xfer_waits != exp_waits) begin
      $display("FAILED at %0d ns: read 0x%02h took %0d wait cycles, expected %0d",
               $time, addr, xfer_waits, exp_waits);
      count_error();
    end
  endtask

  // Consecutive words that all hold one value
  task automatic block_read(input logic [`NTM_APB_ADDR_W-1:0] base, input int count,
                            input logic [31:0] exp);
    for (int i = 0; i < count; i++) begin
      do_read(`NTM_APB_ADDR_W'(int'(base) + 4 * i), exp);
    end
  endtask

  // START, then poll STATUS until the step shows busy
  task automatic start_step();
    logic [31:0] rdata;
    logic        err;
    int          polls;
    step_base = done_cnt;
    do_write(REG_CTRL, 32'(CMD_START), 1'b0);
    polls = 0;
    rdata = '0;
    while (rdata[0] !== 1'b1 && polls < BUSY_POLLS) begin
      apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
      polls++;
    end
    checks++;
    test_checks++;
    if (rdata[0] !== 1'b1) begin
      $display("ERROR: STATUS never showed busy after START");
      count_error();
    end
  endtask

  // Wait for the done pulse, then idle STATUS and a single pulse
  task automatic finish_step();
    int cycles;
    cycles = 0;
    while (done_cnt == step_base && cycles < STEP_LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    checks++;
    test_checks++;
    if (done_cnt == step_base) begin
      $display("ERROR: no done pulse within %0d cycles after START", STEP_LIMIT);
      count_error();
    end
    do_read(REG_STATUS, 32'h0);
    checks++;
    test_checks++;
    if (done_cnt != step_base + 1) begin
      $display("FAILED at %0d ns: %0d done pulses in one step, expected 1",
               $time, done_cnt - step_base);
      count_error();
    end
  endtask

  function automatic string test_name(input int num);
    case (num)
      1: return "reset state";
      2: return "one step";
      3: return "accumulation";
      4: return "clear";
      5: return "slave errors";
      6: return "busy and done";
      default: return "unnamed";
    endcase
  endfunction

  task automatic end_test(input int num);
    tests_run++;
    $display("test %0d %s: %0d checks, %0d errors", num, test_name(num),
             test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  //////////////////////////////
  // Stim script
  //////////////////////////////

  task automatic run_op(input logic [63:0] op, input logic [31:0] addr,
                        input logic [31:0] data, input logic [31:0] exp);
    case (op)
      "W": do_write(addr[`NTM_APB_ADDR_W-1:0], data, exp[0]);
      "R": do_read(addr[`NTM_APB_ADDR_W-1:0], exp);
      "B": block_read(addr[`NTM_APB_ADDR_W-1:0], int'(data), exp);
      "G": start_step();
      "D": finish_step();
      "S": begin
        start_step();
        finish_step();
      end
      "T": end_test(int'(addr));
      default: begin
        $display("ERROR: unknown stim op %s", op);
        count_error();
      end
    endcase
  endtask

  // Newline count, -1 when the file is missing
  function automatic int count_lines();
    int fd;
    int ch;
    int n;
    fd = $fopen(STIM_PATH, "r");
    if (fd == 0) return -1;
    n = 0;
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == 10) n++;
      ch = $fgetc(fd);
    end
    $fclose(fd);
    return n;
  endfunction

  task automatic run_script();
    logic [63:0] op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    int          fd;
    int          rc;
    int          ch;
    fd = $fopen(STIM_PATH, "r");
    rc = $fscanf(fd, "%s", op);
    while (rc == 1) begin
      if (op == "#") begin
        // Comment line
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
      end else begin
        rc = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
        if (rc != 3) begin
          $display("ERROR: stim line for op %s has missing fields", op);
          count_error();
        end else begin
          run_op(op, f_addr, f_data, f_exp);
        end
      end
      rc = $fscanf(fd, "%s", op);
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int n_lines;
    RST     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RST = 1'b0;

    n_lines = count_lines();
    if (n_lines < 0) begin
      $display("ERROR: cannot open stim file %s", STIM_PATH);
      count_error();
    end else begin
      watchdog_ns = (n_lines + 1) * 40 * CLK_PERIOD_NS;
      run_script();
    end

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
